// ==== Makefile ====
TOP := tb_rv_retire_checker

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -f sim.f --top-module $(TOP) -o $(TOP)

# make fails when the pass line is missing from the output
run: build
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module rv_retire_checker

clean:
	rm -rf obj_dir

// ==== rv_check_pkg.sv ====
package rv_check_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // sequential pc increment
    localparam word_t PC_STEP = 32'd4;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_R     = 7'b0110011,
        OPC_I     = 7'b0010011,
        OPC_IL    = 7'b0000011,
        OPC_S     = 7'b0100011,
        OPC_B     = 7'b1100011,
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111,
        OPC_E     = 7'b1110011
    } opcode_t;

    // loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // immediate alu ops, also shared by the R-type encodings
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRI   = 3'b101;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    // fences
    localparam logic [2:0] F3_FENCE   = 3'b000;
    localparam logic [2:0] F3_FENCE_I = 3'b001;

    // normal and alternate (SUB, SRA, SRAI) forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // what the checker does with a retirement
    typedef enum logic [2:0] {
        KIND_XORI,
        KIND_AUIPC,
        KIND_JAL,
        KIND_LB,
        KIND_BLT,
        KIND_SEQ,
        KIND_CTRL
    } inst_kind_t;

endpackage

// ==== rv_flow_tracker.sv ====
`timescale 1ns/1ps

module rv_flow_tracker
    import rv_check_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       retire_i,
    input  inst_kind_t kind_i,
    input  word_t      pc_i,
    input  word_t      rs1_val_i,
    input  word_t      rs2_val_i,
    input  word_t      imm_b_i,
    input  word_t      imm_j_i,
    output logic       pc_mismatch_o
);

    logic  armed;
    logic  blt_taken;
    word_t exp_pc;
    word_t next_pc;

    assign blt_taken = $signed(rs1_val_i) < $signed(rs2_val_i);

    // where the next valid retirement has to be
    always_comb begin
        case (kind_i)
            KIND_JAL: next_pc = pc_i + imm_j_i;
            KIND_BLT: next_pc = blt_taken ? (pc_i + imm_b_i) : (pc_i + PC_STEP);
            default: next_pc = pc_i + PC_STEP;
        endcase
    end

    // only checked once a known successor exists
    assign pc_mismatch_o = retire_i && armed && (pc_i != exp_pc);

    // idle cycles leave the expectation untouched
    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (retire_i) begin
            // jalr, other branches and illegal words have no predictable target
            armed <= (kind_i != KIND_CTRL);
        end
    end

    always_ff @(posedge clk) begin
        if (retire_i) begin
            exp_pc <= next_pc;
        end
    end

endmodule

// ==== rv_inst_decode.sv ====
`timescale 1ns/1ps

module rv_inst_decode
    import rv_check_pkg::*;
(
    input  word_t      inst_i,
    output inst_kind_t kind_o,
    output logic       legal_o,
    output reg_idx_t   rd_o,
    output word_t      imm_i_o,
    output word_t      imm_b_o,
    output word_t      imm_j_o,
    output word_t      imm_u_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       no_regs;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];

    // rs1 and rd both zero, needed by fences
    assign no_regs = (inst_i[19:15] == 5'd0) && (inst_i[11:7] == 5'd0);

    // sign-extended immediates
    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u_o = {inst_i[31:12], 12'd0};

    always_comb begin
        legal_o = 1'b0;
        case (inst_i[6:0])
            OPC_LUI, OPC_AUIPC: legal_o = 1'b1;
            OPC_JAL: legal_o = (imm_j_o[1:0] == 2'b00);
            OPC_JALR: legal_o = (funct3 == 3'b000) && (imm_i_o[1:0] == 2'b00);
            OPC_B: legal_o = (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
                && (imm_b_o[1:0] == 2'b00);
            OPC_IL: legal_o = funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
            OPC_S: legal_o = funct3 inside {F3_SB, F3_SH, F3_SW};
            OPC_I: legal_o = (funct3 inside {F3_ADDI, F3_SLTI, F3_SLTIU, F3_XORI, F3_ORI, F3_ANDI})
                || ((funct3 == F3_SLLI) && (funct7 == F7_BASE))
                || ((funct3 == F3_SRI) && (funct7 inside {F7_BASE, F7_ALT}));
            OPC_R: legal_o = (funct7 == F7_BASE)
                || ((funct7 == F7_ALT) && (funct3 inside {F3_ADDI, F3_SRI}));
            // fence allows pred/succ only, fence.i no fields at all
            OPC_FENCE: legal_o = no_regs
                && (((funct3 == F3_FENCE) && (inst_i[31:28] == 4'd0))
                || ((funct3 == F3_FENCE_I) && (inst_i[31:20] == 12'd0)));
            // ecall/ebreak differ only in bit 20
            OPC_E: legal_o = (inst_i[31:21] == 11'd0) && (inst_i[19:7] == 13'd0);
            default: legal_o = 1'b0;
        endcase
    end

    always_comb begin
        kind_o = KIND_SEQ;
        case (inst_i[6:0])
            OPC_AUIPC: kind_o = KIND_AUIPC;
            OPC_JAL: kind_o = KIND_JAL;
            OPC_JALR: kind_o = KIND_CTRL;
            OPC_B: kind_o = (funct3 == F3_BLT) ? KIND_BLT : KIND_CTRL;
            OPC_I: kind_o = (funct3 == F3_XORI) ? KIND_XORI : KIND_SEQ;
            OPC_IL: kind_o = (funct3 == F3_LB) ? KIND_LB : KIND_SEQ;
            default: kind_o = KIND_SEQ;
        endcase
    end

endmodule

// ==== rv_result_model.sv ====
`timescale 1ns/1ps

module rv_result_model
    import rv_check_pkg::*;
(
    input  inst_kind_t kind_i,
    input  reg_idx_t   rd_i,
    input  word_t      imm_i_i,
    input  word_t      imm_u_i,
    input  word_t      pc_i,
    input  word_t      rs1_val_i,
    input  word_t      mem_addr_i,
    input  word_t      mem_rdata_i,
    input  logic       wb_we_i,
    input  reg_idx_t   wb_dst_i,
    input  word_t      wb_data_i,
    output logic       data_mismatch_o
);

    word_t      exp_addr;
    word_t      exp_val;
    logic [7:0] lb_byte;
    logic       checked;
    logic       exp_we;
    logic       we_bad;
    logic       dst_bad;
    logic       val_bad;
    logic       addr_bad;

    // load address, rs1 + sign-extended offset
    assign exp_addr = rs1_val_i + imm_i_i;

    // byte lane picked by the low address bits
    always_comb begin
        case (exp_addr[1:0])
            2'd0: lb_byte = mem_rdata_i[7:0];
            2'd1: lb_byte = mem_rdata_i[15:8];
            2'd2: lb_byte = mem_rdata_i[23:16];
            default: lb_byte = mem_rdata_i[31:24];
        endcase
    end

    always_comb begin
        checked = 1'b1;
        exp_val = '0;
        case (kind_i)
            KIND_XORI: exp_val = rs1_val_i ^ imm_i_i;
            KIND_AUIPC: exp_val = pc_i + imm_u_i;
            // link value
            KIND_JAL: exp_val = pc_i + PC_STEP;
            KIND_LB: exp_val = {{24{lb_byte[7]}}, lb_byte};
            default: checked = 1'b0;
        endcase
    end

    // x0 is never written
    assign exp_we = (rd_i != 5'd0);

    assign we_bad  = (wb_we_i != exp_we);
    assign dst_bad = (wb_dst_i != rd_i);

    // value is don't-care when rd is x0
    assign val_bad  = exp_we && (wb_data_i != exp_val);
    assign addr_bad = (kind_i == KIND_LB) && (mem_addr_i != exp_addr);

    assign data_mismatch_o = checked && (we_bad || dst_bad || val_bad || addr_bad);

endmodule

// ==== rv_retire_checker.sv ====
`timescale 1ns/1ps

module rv_retire_checker
    import rv_check_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     retire_valid_i,
    input  word_t    retire_inst_i,
    input  word_t    retire_pc_i,
    input  word_t    rs1_val_i,
    input  word_t    rs2_val_i,
    input  logic     wb_we_i,
    input  reg_idx_t wb_dst_i,
    input  word_t    wb_data_i,
    input  word_t    mem_addr_i,
    input  word_t    mem_rdata_i,
    output logic     illegal_o,
    output logic     data_err_o,
    output logic     pc_err_o
);

    inst_kind_t dec_kind;
    logic       dec_legal;
    reg_idx_t   dec_rd;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    logic       legal_ret;
    inst_kind_t model_kind;
    inst_kind_t flow_kind;
    logic       data_mismatch;
    logic       pc_mismatch;

    rv_inst_decode u_decode (
        .inst_i  (retire_inst_i),
        .kind_o  (dec_kind),
        .legal_o (dec_legal),
        .rd_o    (dec_rd),
        .imm_i_o (imm_i),
        .imm_b_o (imm_b),
        .imm_j_o (imm_j),
        .imm_u_o (imm_u)
    );

    assign legal_ret = retire_valid_i && dec_legal;

    // KIND_SEQ is never checked, so idle and illegal cycles stay quiet
    assign model_kind = legal_ret ? dec_kind : KIND_SEQ;

    // an illegal word makes the tracker drop its expectation
    assign flow_kind = dec_legal ? dec_kind : KIND_CTRL;

    rv_result_model u_model (
        .kind_i          (model_kind),
        .rd_i            (dec_rd),
        .imm_i_i         (imm_i),
        .imm_u_i         (imm_u),
        .pc_i            (retire_pc_i),
        .rs1_val_i       (rs1_val_i),
        .mem_addr_i      (mem_addr_i),
        .mem_rdata_i     (mem_rdata_i),
        .wb_we_i         (wb_we_i),
        .wb_dst_i        (wb_dst_i),
        .wb_data_i       (wb_data_i),
        .data_mismatch_o (data_mismatch)
    );

    rv_flow_tracker u_flow (
        .clk           (clk),
        .rst           (rst),
        .retire_i      (retire_valid_i),
        .kind_i        (flow_kind),
        .pc_i          (retire_pc_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .imm_b_i       (imm_b),
        .imm_j_i       (imm_j),
        .pc_mismatch_o (pc_mismatch)
    );

    // error pulses one cycle after the offending retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            illegal_o  <= 1'b0;
            data_err_o <= 1'b0;
            pc_err_o   <= 1'b0;
        end else begin
            illegal_o  <= retire_valid_i && !dec_legal;
            // stray write with nothing retiring
            data_err_o <= data_mismatch || (wb_we_i && !retire_valid_i);
            pc_err_o   <= pc_mismatch && legal_ret;
        end
    end

endmodule

// ==== sim.f ====
rv_check_pkg.sv
rv_inst_decode.sv
rv_result_model.sv
rv_flow_tracker.sv
rv_retire_checker.sv
tb_rv_retire_checker.sv

// ==== tb_rv_retire_checker.sv ====
`timescale 1ns/1ps

module tb_rv_retire_checker
    import rv_check_pkg::*;
();

    typedef struct packed {
        logic       valid;
        word_t      inst;
        word_t      pc;
        word_t      rs1;
        word_t      rs2;
        logic       we;
        reg_idx_t   dst;
        word_t      data;
        word_t      addr;
        word_t      rdata;
        logic [2:0] flags;
    } row_t;

    logic     clk;
    logic     rst;
    logic     retire_valid;
    word_t    retire_inst;
    word_t    retire_pc;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     wb_we;
    reg_idx_t wb_dst;
    word_t    wb_data;
    word_t    mem_addr;
    word_t    mem_rdata;
    logic     illegal;
    logic     data_err;
    logic     pc_err;

    row_t  rows[$];
    string names[$];
    int    num_rows = 0;
    int    seed = 2110;

    rv_retire_checker dut (
        .clk            (clk),
        .rst            (rst),
        .retire_valid_i (retire_valid),
        .retire_inst_i  (retire_inst),
        .retire_pc_i    (retire_pc),
        .rs1_val_i      (rs1_val),
        .rs2_val_i      (rs2_val),
        .wb_we_i        (wb_we),
        .wb_dst_i       (wb_dst),
        .wb_data_i      (wb_data),
        .mem_addr_i     (mem_addr),
        .mem_rdata_i    (mem_rdata),
        .illegal_o      (illegal),
        .data_err_o     (data_err),
        .pc_err_o       (pc_err)
    );

    always #50 clk = ~clk;

    // instruction encoders, rs1 field is always x1
    function automatic word_t enc_i(logic [2:0] f3, reg_idx_t rd, logic [11:0] imm, opcode_t opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, OPC_AUIPC};
    endfunction

    function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t enc_blt(logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, F3_BLT, off[4:1], off[11], OPC_B};
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // byte at the given offset, sign-extended
    function automatic word_t lb_lane(word_t w, logic [1:0] off);
        word_t lane;
        lane = w >> (8 * off);
        return {{24{lane[7]}}, lane[7:0]};
    endfunction

    task automatic add_row(input string name, input logic valid, input word_t inst,
                           input word_t pc, input word_t rs1, input word_t rs2, input logic we,
                           input reg_idx_t dst, input word_t data, input word_t addr,
                           input word_t rdata, input logic [2:0] flags);
        row_t r;
        r = '{valid, inst, pc, rs1, rs2, we, dst, data, addr, rdata, flags};
        rows.push_back(r);
        names.push_back(name);
    endtask

    // retirement without write-back
    task automatic add_no_wb(input string name, input word_t inst, input word_t pc,
                             input word_t rs1, input word_t rs2, input logic [2:0] flags);
        add_row(name, 1'b1, inst, pc, rs1, rs2, 1'b0, 5'd0, 0, 0, 0, flags);
    endtask

    task automatic add_seq(input string name, input word_t pc, input logic [2:0] flags);
        add_no_wb(name, enc_i(F3_ADDI, 5'd0, 12'h000, OPC_I), pc, 0, 0, flags);
    endtask

    task automatic build_table();
        word_t       rnd;
        word_t       rs1;
        logic [11:0] imm;
        word_t       lb_data;
        lb_data = 32'h807f_c311;
        // tracker disarmed after reset, any pc is fine
        add_row("xori_first", 1'b1, enc_i(F3_XORI, 5'd5, 12'h0f0, OPC_I), 32'h100, 32'h0000_00ff,
                0, 1'b1, 5'd5, 32'h0000_00ff ^ sext12(12'h0f0), 0, 0, 3'b000);
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            rs1 = $random(seed);
            imm = rnd[11:0];
            add_row($sformatf("xori_rand%0d", k), 1'b1, enc_i(F3_XORI, 5'd7, imm, OPC_I),
                    32'h104 + 4 * k, rs1, 0, 1'b1, 5'd7, rs1 ^ sext12(imm), 0, 0, 3'b000);
        end
        add_row("auipc", 1'b1, enc_u(5'd6, 20'h12345), 32'h110, 0, 0,
                1'b1, 5'd6, 32'h110 + {20'h12345, 12'h000}, 0, 0, 3'b000);
        add_row("jal_fwd", 1'b1, enc_j(5'd1, 21'h00040), 32'h114, 0, 0,
                1'b1, 5'd1, 32'h118, 0, 0, 3'b000);
        for (int k = 0; k < 4; k++) begin
            add_row($sformatf("lb_off%0d", k), 1'b1, enc_i(F3_LB, 5'd9, 12'(k), OPC_IL),
                    32'h154 + 4 * k, 32'h2000, 0, 1'b1, 5'd9, lb_lane(lb_data, k[1:0]),
                    32'h2000 + k, lb_data, 3'b000);
        end
        add_row("idle0", 1'b0, 0, 0, 0, 0, 1'b0, 5'd0, 0, 0, 0, 3'b000);
        // stale xori word left on the bus while idle
        add_row("idle1", 1'b0, enc_i(F3_XORI, 5'd5, 12'h001, OPC_I), 0, 0, 0, 1'b0, 5'd0, 0, 0,
                0, 3'b000);
        // x10 ^ 1 is 0x11
        add_row("xori_bad_val", 1'b1, enc_i(F3_XORI, 5'd5, 12'h001, OPC_I), 32'h164, 32'h10,
                0, 1'b1, 5'd5, 32'h10, 0, 0, 3'b010);
        add_row("xori_bad_dst", 1'b1, enc_i(F3_XORI, 5'd5, 12'h001, OPC_I), 32'h168, 32'h10,
                0, 1'b1, 5'd4, 32'h11, 0, 0, 3'b010);
        add_row("xori_we_x0", 1'b1, enc_i(F3_XORI, 5'd0, 12'h001, OPC_I), 32'h16c, 32'h10,
                0, 1'b1, 5'd0, 32'h11, 0, 0, 3'b010);
        add_row("lb_bad_addr", 1'b1, enc_i(F3_LB, 5'd9, 12'h000, OPC_IL), 32'h170, 32'h2000,
                0, 1'b1, 5'd9, lb_lane(lb_data, 2'd0), 32'h2004, lb_data, 3'b010);
        add_row("stray_we", 1'b0, 0, 0, 0, 0, 1'b1, 5'd3, 0, 0, 0, 3'b010);
        add_seq("seq_bad_pc", 32'h200, 3'b001);
        // signed compare, -5 < 3
        add_no_wb("blt_taken", enc_blt(13'h0020), 32'h204, 32'hffff_fffb, 32'h3, 3'b000);
        add_seq("blt_taken_tgt", 32'h224, 3'b000);
        add_no_wb("blt_not_taken", enc_blt(13'h0040), 32'h228, 32'h7, 32'hffff_ffff, 3'b000);
        add_seq("blt_bad_tgt", 32'h268, 3'b001);
        add_no_wb("jal_back", enc_j(5'd0, 21'h1f_fff0), 32'h26c, 0, 0, 3'b000);
        add_seq("jal_bad_tgt", 32'h270, 3'b001);
        add_no_wb("jalr", enc_i(3'b000, 5'd0, 12'h000, OPC_JALR), 32'h274, 0, 0, 3'b000);
        add_seq("after_jalr", 32'h800, 3'b000);
        // off the expected pc, still only illegal_o
        add_no_wb("r_bad_funct7", {7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OPC_R}, 32'h808, 0, 0, 3'b100);
        add_seq("after_r_bad", 32'h900, 3'b000);
        add_no_wb("fence_rd", enc_i(F3_FENCE, 5'd1, 12'h0ff, OPC_FENCE), 32'h904, 0, 0, 3'b100);
        add_seq("after_fence", 32'ha00, 3'b000);
    endtask

    task automatic drive_row(input row_t r);
        retire_valid = r.valid;
        retire_inst  = r.inst;
        retire_pc    = r.pc;
        rs1_val      = r.rs1;
        rs2_val      = r.rs2;
        wb_we        = r.we;
        wb_dst       = r.dst;
        wb_data      = r.data;
        mem_addr     = r.addr;
        mem_rdata    = r.rdata;
    endtask

    task automatic check_illegal(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s illegal_o expected %b actual %b", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "illegal_o check failed");
        end
    endtask

    task automatic check_data(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s data_err_o expected %b actual %b", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "data_err_o check failed");
        end
    endtask

    task automatic check_pc(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s pc_err_o expected %b actual %b", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "pc_err_o check failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        drive_row('0);
        build_table();
        num_rows = rows.size();
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        // flags of a row show up one edge after it is driven
        for (int i = 0; i < num_rows; i++) begin
            drive_row(rows[i]);
            @(posedge clk);
            #5;
            check_illegal(names[i], rows[i].flags[2], illegal);
            check_data(names[i], rows[i].flags[1], data_err);
            check_pc(names[i], rows[i].flags[0], pc_err);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        wait (num_rows > 0);
        #((num_rows + 10) * 100);
        $display("timeout: the table did not finish within the expected run time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
